// ==== design/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  localparam int addr_w = 16;
  localparam int data_w = 32;

  // word addresses, not byte addresses
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
  } wb_m2s_t;

  typedef struct packed {
    logic  ack;
    data_t dat;
  } wb_s2m_t;

  // sequencer to memory manager
  typedef struct packed {
    logic  valid;
    logic  write;
    logic  region;
    addr_t offset;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  done;
    data_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== design/cpu_types_pkg.sv ====
`default_nettype none

package cpu_types_pkg;

  // command opcodes, top nibble of every command word
  typedef enum logic [3:0] {
    op_add  = 4'h1,
    op_sub  = 4'h2,
    op_and  = 4'h3,
    op_or   = 4'h4,
    op_xor  = 4'h5,
    op_jmp  = 4'h8,
    op_jz   = 4'h9,
    op_halt = 4'hf
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4
  } alu_op_t;

  // arithmetic view: offsets into data space
  typedef struct packed {
    opcode_t    opcode;
    logic [7:0] dst;
    logic [7:0] src1;
    logic [7:0] src0;
    logic [3:0] unused;
  } cmd_arith_t;

  // control view: target is an offset into command space
  typedef struct packed {
    opcode_t     opcode;
    logic [11:0] unused;
    logic [15:0] target;
  } cmd_ctrl_t;

  // one command word, read through either view by opcode
  typedef union packed {
    cmd_arith_t arith;
    cmd_ctrl_t  ctrl;
  } command_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_read1,
    st_read0,
    st_exec,
    st_write,
    st_halted
  } core_state_t;

  // memory regions seen by the sequencer
  localparam logic rgn_cmd  = 1'b0;
  localparam logic rgn_data = 1'b1;

  function automatic logic is_arith(opcode_t op);
    return op inside {op_add, op_sub, op_and, op_or, op_xor};
  endfunction

  function automatic alu_op_t to_alu_op(opcode_t op);
    case (op)
      op_sub:  return alu_sub;
      op_and:  return alu_and;
      op_or:   return alu_or;
      op_xor:  return alu_xor;
      default: return alu_add;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu
  import bus_pkg::*;
  import cpu_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  alu_op_t op,
  input  data_t   a,
  input  data_t   b,
  output data_t   result,
  output logic    zero,
  output logic    done
);

  data_t calc;

  // sub is a minus b, i.e. src1 - src0
  always_comb begin
    case (op)
      alu_add: calc = a + b;
      alu_sub: calc = a - b;
      alu_and: calc = a & b;
      alu_or:  calc = a | b;
      alu_xor: calc = a ^ b;
      default: calc = a;
    endcase
  end

  // zero flag only moves on start, so jumps see the last result
  always_ff @(posedge clk) begin
    if (rst) begin
      zero <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= start;
      if (start) begin
        zero <= (calc == '0);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      result <= calc;
    end
  end

endmodule

`default_nettype wire

// ==== design/mem_manager.sv ====
`default_nettype none

module mem_manager
  import bus_pkg::*;
  import cpu_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  addr_t    base_addr,
  input  addr_t    base_addr_data,
  input  mem_req_t req,
  input  wb_s2m_t  wb_in,
  output mem_rsp_t rsp,
  output wb_m2s_t  wb_out
);

  typedef enum logic {
    mm_idle,
    mm_active
  } mm_state_t;

  mm_state_t state;
  logic      busy;
  logic      accept;
  addr_t     base;
  addr_t     bus_adr;
  logic      bus_we;
  data_t     bus_dat;
  logic      done_q;
  data_t     rdata_q;

  assign busy = (state == mm_active);

  // base of the requested region
  assign base = (req.region == rgn_data) ? base_addr_data : base_addr;

  // ignore the request still shown during the done cycle
  assign accept = !busy && req.valid && !done_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= mm_idle;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        mm_idle: begin
          if (accept) begin
            state <= mm_active;
          end
        end
        mm_active: begin
          if (wb_in.ack) begin
            state  <= mm_idle;
            done_q <= 1'b1;
          end
        end
        default: state <= mm_idle;
      endcase
    end
  end

  // bus fields latched on accept and held until ack
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_we <= 1'b0;
    end else if (accept) begin
      bus_adr <= base + req.offset;
      bus_we  <= req.write;
      bus_dat <= req.wdata;
    end
    if (busy && wb_in.ack) begin
      rdata_q <= wb_in.dat;
    end
  end

  // cyc and stb rise and fall together
  assign wb_out = '{
    cyc: busy,
    stb: busy,
    we:  bus_we,
    adr: bus_adr,
    dat: bus_dat
  };

  assign rsp = '{
    done:  done_q,
    rdata: rdata_q
  };

endmodule

`default_nettype wire

// ==== design/state_manager.sv ====
`default_nettype none

module state_manager
  import bus_pkg::*;
  import cpu_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  mem_rsp_t rsp,
  input  logic     alu_done,
  input  data_t    alu_result,
  input  logic     zero,
  output mem_req_t req,
  output logic     alu_start,
  output alu_op_t  alu_op,
  output data_t    alu_a,
  output data_t    alu_b,
  output logic     halted
);

  core_state_t state;
  addr_t       ptr;
  command_t    cmd;
  opcode_t     opc;
  data_t       wr_data;
  // high for the cycle after done, keeps valid low between requests
  logic        rsp_gap;

  assign opc    = cmd.arith.opcode;
  assign alu_op = to_alu_op(opc);
  assign halted = (state == st_halted);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_fetch;
      ptr       <= '0;
      rsp_gap   <= 1'b0;
      alu_start <= 1'b0;
    end else begin
      rsp_gap   <= rsp.done;
      alu_start <= 1'b0;
      case (state)
        st_fetch: begin
          if (rsp.done) begin
            state <= st_decode;
          end
        end
        st_decode: begin
          if (is_arith(opc)) begin
            state <= st_read1;
          end else begin
            state <= st_fetch;
            case (opc)
              op_jmp:  ptr <= cmd.ctrl.target;
              op_jz:   ptr <= zero ? cmd.ctrl.target : ptr + 1'b1;
              op_halt: state <= st_halted;
              // unknown codes fall through as no-ops
              default: ptr <= ptr + 1'b1;
            endcase
          end
        end
        st_read1: begin
          if (rsp.done) begin
            state <= st_read0;
          end
        end
        st_read0: begin
          if (rsp.done) begin
            state     <= st_exec;
            alu_start <= 1'b1;
          end
        end
        st_exec: begin
          if (alu_done) begin
            state <= st_write;
          end
        end
        st_write: begin
          if (rsp.done) begin
            ptr   <= ptr + 1'b1;
            state <= st_fetch;
          end
        end
        st_halted: state <= st_halted;
        default:   state <= st_fetch;
      endcase
    end
  end

  // command and operand capture
  always_ff @(posedge clk) begin
    if (rsp.done) begin
      case (state)
        st_fetch: cmd   <= rsp.rdata;
        st_read1: alu_a <= rsp.rdata;
        st_read0: alu_b <= rsp.rdata;
        default:  ;
      endcase
    end
    if (alu_done) begin
      wr_data <= alu_result;
    end
  end

  always_comb begin
    req       = '0;
    req.wdata = wr_data;
    case (state)
      st_fetch: begin
        req.valid  = !rsp_gap;
        req.region = rgn_cmd;
        req.offset = ptr;
      end
      st_read1: begin
        req.valid  = !rsp_gap;
        req.region = rgn_data;
        req.offset = addr_t'(cmd.arith.src1);
      end
      st_read0: begin
        req.valid  = !rsp_gap;
        req.region = rgn_data;
        req.offset = addr_t'(cmd.arith.src0);
      end
      st_write: begin
        req.valid  = !rsp_gap;
        req.write  = 1'b1;
        req.region = rgn_data;
        req.offset = addr_t'(cmd.arith.dst);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/cpu_core.sv ====
`default_nettype none

module cpu_core
  import bus_pkg::*;
  import cpu_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  addr_t   base_addr,
  input  addr_t   base_addr_data,
  output wb_m2s_t wb_out,
  input  wb_s2m_t wb_in,
  output logic    halted
);

  mem_req_t req;
  mem_rsp_t rsp;
  logic     alu_start;
  alu_op_t  alu_op;
  data_t    alu_a;
  data_t    alu_b;
  data_t    alu_result;
  logic     alu_zero;
  logic     alu_done;

  // command sequencer
  state_manager seq0 (
    .clk        (clk),
    .rst        (rst),
    .rsp        (rsp),
    .alu_done   (alu_done),
    .alu_result (alu_result),
    .zero       (alu_zero),
    .req        (req),
    .alu_start  (alu_start),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .halted     (halted)
  );

  // wishbone master, adds the region base
  mem_manager mem0 (
    .clk            (clk),
    .rst            (rst),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .req            (req),
    .wb_in          (wb_in),
    .rsp            (rsp),
    .wb_out         (wb_out)
  );

  alu alu0 (
    .clk    (clk),
    .rst    (rst),
    .start  (alu_start),
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .zero   (alu_zero),
    .done   (alu_done)
  );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`default_nettype none

module clock_gen (
  output logic clk
);

  // period 40
  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

endmodule

`default_nettype wire

// ==== bench/wb_memory.sv ====
`default_nettype none

module wb_memory
  import bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  wb_m2s_t     bus_in,
  output wb_s2m_t     bus_out,
  input  logic        load_en,
  input  logic [11:0] load_adr,
  input  data_t       load_dat
);

  data_t      mem [4096];
  logic [1:0] wait_cnt;
  logic       ack;
  data_t      rdata;

  // fill pattern built from the full 12-bit address
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i[11:0]] <= {4'hd, 12'(i), 4'h5, 12'(~i)};
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      ack      <= 1'b0;
      wait_cnt <= '0;
    end else begin
      ack <= 1'b0;
      if (bus_in.cyc && bus_in.stb && !ack) begin
        if (wait_cnt == '0) begin
          ack      <= 1'b1;
          rdata    <= mem[bus_in.adr[11:0]];
          wait_cnt <= 2'($urandom_range(3, 0));
          if (bus_in.we) begin
            mem[bus_in.adr[11:0]] <= bus_in.dat;
          end
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
    // bench side loading, works in reset too
    if (load_en) begin
      mem[load_adr] <= load_dat;
    end
  end

  assign bus_out = '{ack: ack, dat: rdata};

endmodule

`default_nettype wire

// ==== bench/cpu_core_chk.sv ====
`default_nettype none

module cpu_core_chk
  import bus_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input wb_m2s_t wb_out,
  input wb_s2m_t wb_in,
  input logic    halted
);

  int fail_count;

  initial begin
    fail_count = 0;
  end

  stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
    wb_out.stb |-> wb_out.cyc)
    else begin
      $error("stb high outside a bus cycle");
      fail_count++;
    end

  // classic cycle, master holds everything while waiting for ack
  fields_held: assert property (@(posedge clk) disable iff (rst)
    (wb_out.stb && !wb_in.ack) |=>
      ($stable(wb_out.adr) && $stable(wb_out.we) && $stable(wb_out.dat)))
    else begin
      $error("bus fields changed while waiting for ack");
      fail_count++;
    end

  no_cyc_halted: assert property (@(posedge clk) disable iff (rst)
    halted |-> !wb_out.cyc)
    else begin
      $error("bus cycle while halted");
      fail_count++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted)
    else begin
      $error("halted dropped without reset");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== bench/cpu_core_tb.sv ====
`default_nettype none

module cpu_core_tb
  import bus_pkg::*;
  import cpu_types_pkg::*;
();

  logic        clk;
  logic        rst;
  addr_t       base_addr;
  addr_t       base_addr_data;
  wb_m2s_t     wb_out;
  wb_s2m_t     wb_in;
  logic        halted;
  logic        load_en;
  logic [11:0] load_adr;
  data_t       load_dat;

  // expected memory image
  data_t shadow [4096];
  int    test_errs;
  int    tests_run;
  int    tests_failed;

  clock_gen clk0 (.clk(clk));

  cpu_core dut0 (
    .clk            (clk),
    .rst            (rst),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .wb_out         (wb_out),
    .wb_in          (wb_in),
    .halted         (halted)
  );

  wb_memory ram0 (
    .clk      (clk),
    .rst      (rst),
    .bus_in   (wb_out),
    .bus_out  (wb_in),
    .load_en  (load_en),
    .load_adr (load_adr),
    .load_dat (load_dat)
  );

  bind cpu_core cpu_core_chk chk0 (
    .clk    (clk),
    .rst    (rst),
    .wb_out (wb_out),
    .wb_in  (wb_in),
    .halted (halted)
  );

  function automatic data_t arith_word(opcode_t op, int dst, int src1, int src0);
    return {op, 8'(dst), 8'(src1), 8'(src0), 4'h0};
  endfunction

  function automatic data_t ctrl_word(opcode_t op, int target);
    return {op, 12'h0, 16'(target)};
  endfunction

  // memory model only decodes 12 address bits
  function automatic logic [11:0] word_index(addr_t base, int offset);
    addr_t a;
    a = base + 16'(offset);
    return a[11:0];
  endfunction

  task automatic load_word(addr_t base, int offset, data_t d);
    @(posedge clk);
    load_en  <= 1'b1;
    load_adr <= word_index(base, offset);
    load_dat <= d;
    shadow[word_index(base, offset)] = d;
  endtask

  // overflow, borrow and random operands for every alu op
  task automatic load_arith_prog(addr_t cb, addr_t db, data_t x, data_t y);
    load_word(db, 0, 32'hffff_ffff);
    load_word(db, 1, 32'h0000_0002);
    load_word(db, 2, 32'h0000_0001);
    load_word(db, 3, x);
    load_word(db, 4, y);
    load_word(cb, 0, arith_word(op_add, 16, 0, 1));
    load_word(cb, 1, arith_word(op_sub, 17, 2, 1));
    load_word(cb, 2, arith_word(op_and, 18, 3, 4));
    load_word(cb, 3, arith_word(op_or, 19, 3, 4));
    load_word(cb, 4, arith_word(op_xor, 20, 3, 4));
    load_word(cb, 5, arith_word(op_add, 21, 3, 4));
    load_word(cb, 6, arith_word(op_sub, 22, 4, 3));
    load_word(cb, 7, ctrl_word(op_halt, 0));
  endtask

  task automatic load_jmp_prog(addr_t cb, addr_t db);
    load_word(db, 0, $urandom());
    load_word(db, 1, $urandom());
    load_word(cb, 0, arith_word(op_add, 16, 0, 1));
    load_word(cb, 1, ctrl_word(op_jmp, 3));
    load_word(cb, 2, arith_word(op_xor, 17, 0, 1));
    load_word(cb, 3, arith_word(op_add, 18, 1, 1));
    load_word(cb, 4, ctrl_word(op_halt, 0));
  endtask

  // words 11..14 are markers for taken and not taken jz
  task automatic load_jz_prog(addr_t cb, addr_t db);
    data_t z;
    z = $urandom();
    load_word(db, 0, z);
    load_word(db, 1, z);
    load_word(db, 2, z + 32'd5);
    load_word(cb, 0, arith_word(op_sub, 10, 0, 1));
    load_word(cb, 1, ctrl_word(op_jz, 3));
    load_word(cb, 2, arith_word(op_add, 11, 0, 2));
    load_word(cb, 3, arith_word(op_add, 12, 0, 2));
    load_word(cb, 4, arith_word(op_sub, 13, 0, 2));
    load_word(cb, 5, ctrl_word(op_jz, 7));
    load_word(cb, 6, arith_word(op_add, 14, 0, 2));
    load_word(cb, 7, ctrl_word(op_halt, 0));
  endtask

  // behavioral model of the command set that updates shadow
  task automatic run_model(addr_t cb, addr_t db);
    logic [15:0] ptr;
    logic        zf;
    logic        stop;
    data_t       w;
    data_t       a;
    data_t       b;
    data_t       r;
    int          steps;
    ptr = '0;
    zf = 1'b0;
    stop = 1'b0;
    steps = 0;
    while (!stop && steps < 1000) begin
      w = shadow[word_index(cb, int'(ptr))];
      a = shadow[word_index(db, int'(w[19:12]))];
      b = shadow[word_index(db, int'(w[11:4]))];
      steps++;
      case (w[31:28])
        op_add:  r = a + b;
        op_sub:  r = a - b;
        op_and:  r = a & b;
        op_or:   r = a | b;
        op_xor:  r = a ^ b;
        default: r = '0;
      endcase
      case (w[31:28])
        op_add, op_sub, op_and, op_or, op_xor: begin
          shadow[word_index(db, int'(w[27:20]))] = r;
          zf = (r == '0);
          ptr = ptr + 16'd1;
        end
        op_jmp:  ptr = w[15:0];
        op_jz:   ptr = zf ? w[15:0] : ptr + 16'd1;
        op_halt: stop = 1'b1;
        default: ptr = ptr + 16'd1;
      endcase
    end
  endtask

  task automatic check_idle(string when);
    assert (!wb_out.cyc && !wb_out.stb && !wb_out.we && !halted) else begin
      $display("[FAIL] %s reset: cyc=%h stb=%h we=%h halted=%h, expected 0",
               when, wb_out.cyc, wb_out.stb, wb_out.we, halted);
      test_errs++;
    end
  endtask

  task automatic run_test(string name, addr_t cb, addr_t db);
    int cycles;
    int chk_before;
    test_errs = 0;
    chk_before = dut0.chk0.fail_count;
    @(posedge clk);
    load_en        <= 1'b0;
    rst            <= 1'b1;
    base_addr      <= cb;
    base_addr_data <= db;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_idle("during");
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle("after");
    cycles = 0;
    while (!halted && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("test %s: core did not halt within 2000 cycles", name);
      test_errs++;
    end
    // idle time after halt for the bound checks
    repeat (4) @(negedge clk);
    assert (halted) else begin
      $display("[FAIL] %s halted=%h, expected 1", name, halted);
      test_errs++;
    end
    run_model(cb, db);
    for (int i = 0; i < 4096; i++) begin
      assert (ram0.mem[i[11:0]] == shadow[i[11:0]]) else begin
        $display("[FAIL] %s mem[%h] expected %h actual %h",
                 name, i[11:0], shadow[i[11:0]], ram0.mem[i[11:0]]);
        test_errs++;
      end
    end
    test_errs += dut0.chk0.fail_count - chk_before;
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", name, (test_errs == 0) ? "passed" : "failed",
             test_errs);
  endtask

  initial begin
    data_t x;
    data_t y;
    void'($urandom(32'h35a8_461b));
    rst            = 1'b1;
    base_addr      = '0;
    base_addr_data = '0;
    load_en        = 1'b0;
    load_adr       = '0;
    load_dat       = '0;
    tests_run      = 0;
    tests_failed   = 0;
    test_errs      = 0;
    #1;
    for (int i = 0; i < 4096; i++) begin
      shadow[i[11:0]] = ram0.mem[i[11:0]];
    end
    x = $urandom();
    y = $urandom();
    load_arith_prog(16'h0000, 16'h0100, x, y);
    run_test("arith", 16'h0000, 16'h0100);
    load_jmp_prog(16'h0200, 16'h0300);
    run_test("jmp", 16'h0200, 16'h0300);
    load_jz_prog(16'h0400, 16'h0500);
    run_test("jz", 16'h0400, 16'h0500);
    // same program with moved code and fresh operands
    x = $urandom();
    y = $urandom();
    load_arith_prog(16'h0800, 16'h0a00, x, y);
    run_test("relocate", 16'h0800, 16'h0a00);
    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu_core.f ====
design/bus_pkg.sv
design/cpu_types_pkg.sv
design/alu.sv
design/mem_manager.sv
design/state_manager.sv
design/cpu_core.sv
bench/clock_gen.sv
bench/wb_memory.sv
bench/cpu_core_chk.sv
bench/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_core_tb -f cpu_core.f -o cpu_core_sim

out=$(./obj_dir/cpu_core_sim +verilator+error+limit+100)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
else
  exit 1
fi
